// File: rtl/miniCpu_defines.svh
`ifndef MINICPU_DEFINES_SVH
`define MINICPU_DEFINES_SVH

// Width of every datapath word
`define CPU_DATA_W 32

// Data memory size in words
`define CPU_MEM_DEPTH 32

// Word address width, log2 of the memory depth
`define CPU_MEM_ADDR_W 5

// Register file size
`define CPU_REG_COUNT 8

// Register index width, log2 of the register count
`define CPU_REG_ADDR_W 3

`endif

// File: rtl/miniCpuPkg.sv
package miniCpuPkg;

    // Instruction word layout
    //   opcode  bits 31 to 28
    //   rd      bits 27 to 25
    //   rs      bits 24 to 22
    //   rt      bits 21 to 19
    //   imm     bits 15 to 0, sign-extended
    // Codes 8 to 15 decode as no-operation
    typedef enum logic [3:0] {
        opAdd  = 4'd0,
        opSub  = 4'd1,
        opAnd  = 4'd2,
        opOr   = 4'd3,
        opSlt  = 4'd4,
        opAddi = 4'd5,
        opLw   = 4'd6,
        opSw   = 4'd7
    } opcode_t;

    // ALU function select
    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluSlt = 3'd4
    } aluOp_t;

    // Memory command, same two-bit code as the original data memory
    typedef enum logic [1:0] {
        memIdle  = 2'b00,
        memWrite = 2'b01,
        memRead  = 2'b10
    } memCmd_t;

    // Control sequencer states
    typedef enum logic [2:0] {
        sIdle = 3'd0,
        sExec = 3'd1,
        sMem  = 3'd2,
        sWb   = 3'd3
    } ctrlState_t;

endpackage

// File: rtl/regFile.sv
`timescale 1ns/1ps
`include "miniCpu_defines.svh"

module regFile
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`CPU_REG_ADDR_W-1:0] rsAddr,
    input  logic [`CPU_REG_ADDR_W-1:0] rtAddr,
    input  logic                       wrEn,
    input  logic [`CPU_REG_ADDR_W-1:0] wrAddr,
    input  logic [`CPU_DATA_W-1:0]     wrData,
    output logic [`CPU_DATA_W-1:0]     rsData,
    output logic [`CPU_DATA_W-1:0]     rtData
);

    // Register storage
    logic [`CPU_DATA_W-1:0] regs [`CPU_REG_COUNT];

    ////////////////////////////////////////////////////////////
    // Write port
    ////////////////////////////////////////////////////////////

    // Register 0 never takes a write
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `CPU_REG_COUNT; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wrEn && (wrAddr != '0))
        begin
            regs[wrAddr] <= wrData;
        end
    end

    ////////////////////////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////////////////////////

    // Combinational reads, r0 forced to zero
    always_comb
    begin
        rsData = (rsAddr == '0) ? '0 : regs[rsAddr];
        rtData = (rtAddr == '0) ? '0 : regs[rtAddr];
    end

endmodule

// File: rtl/alu.sv
`timescale 1ns/1ps
`include "miniCpu_defines.svh"

module alu
(
    input  miniCpuPkg::aluOp_t     op,
    input  logic [`CPU_DATA_W-1:0] a,
    input  logic [`CPU_DATA_W-1:0] b,
    output logic [`CPU_DATA_W-1:0] y
);

    // Signed compare for set-less-than
    logic lessThan;

    assign lessThan = $signed(a) < $signed(b);

    // Function select
    // Also used for effective address on addi, lw and sw
    always_comb
    begin
        case (op)
            miniCpuPkg::aluAdd:
            begin
                y = a + b;
            end
            miniCpuPkg::aluSub:
            begin
                y = a - b;
            end
            miniCpuPkg::aluAnd:
            begin
                y = a & b;
            end
            miniCpuPkg::aluOr:
            begin
                y = a | b;
            end
            miniCpuPkg::aluSlt:
            begin
                // 1 or 0, zero extended
                y = {{(`CPU_DATA_W-1){1'b0}}, lessThan};
            end
            default:
            begin
                y = '0;
            end
        endcase
    end

endmodule

// File: rtl/dataMemory.sv
`timescale 1ns/1ps
`include "miniCpu_defines.svh"

module dataMemory
(
    input  logic                       clk,
    input  logic                       rst,
    input  miniCpuPkg::memCmd_t        cmd,
    input  logic [`CPU_MEM_ADDR_W-1:0] addr,
    input  logic [`CPU_DATA_W-1:0]     writeData,
    input  logic                       debugOn,
    input  logic [`CPU_MEM_ADDR_W-1:0] debugAddr,
    output logic [`CPU_DATA_W-1:0]     readData,
    output logic [`CPU_DATA_W-1:0]     memDebug
);

    // Word array
    logic [`CPU_DATA_W-1:0] mem [`CPU_MEM_DEPTH];

    ////////////////////////////////////////////////////////////
    // Write side
    ////////////////////////////////////////////////////////////

    // Contents undefined after reset
    always_ff @(posedge clk)
    begin
        if (cmd == miniCpuPkg::memWrite)
        begin
            mem[addr] <= writeData;
        end
    end

    ////////////////////////////////////////////////////////////
    // Read side
    ////////////////////////////////////////////////////////////

    // Command read and debug read are independent
    // Each output holds until its next read
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            readData <= '0;
            memDebug <= '0;
        end
        else
        begin
            if (cmd == miniCpuPkg::memRead)
            begin
                readData <= mem[addr];
            end
            // Debug sample, old data if written same edge
            if (debugOn)
            begin
                memDebug <= mem[debugAddr];
            end
        end
    end

endmodule

// File: rtl/cpuControl.sv
`timescale 1ns/1ps
`include "miniCpu_defines.svh"

module cpuControl
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`CPU_DATA_W-1:0]     instr,
    input  logic                       instrValid,
    input  logic [`CPU_DATA_W-1:0]     rsData,
    input  logic [`CPU_DATA_W-1:0]     rtData,
    input  logic [`CPU_DATA_W-1:0]     aluY,
    input  logic [`CPU_DATA_W-1:0]     readData,
    output logic [`CPU_REG_ADDR_W-1:0] rsAddr,
    output logic [`CPU_REG_ADDR_W-1:0] rtAddr,
    output logic [`CPU_REG_ADDR_W-1:0] wrAddr,
    output logic                       wrEn,
    output miniCpuPkg::aluOp_t         aluOp,
    output logic [`CPU_DATA_W-1:0]     aluA,
    output logic [`CPU_DATA_W-1:0]     aluB,
    output miniCpuPkg::memCmd_t        memCmd,
    output logic [`CPU_MEM_ADDR_W-1:0] memAddr,
    output logic [`CPU_DATA_W-1:0]     memWriteData,
    output logic                       busy,
    output logic                       done,
    output logic [`CPU_DATA_W-1:0]     result
);

    miniCpuPkg::ctrlState_t state;

    // Latched instruction and stage registers
    logic [`CPU_DATA_W-1:0] instrReg;
    logic [`CPU_DATA_W-1:0] aluRes;
    logic [`CPU_DATA_W-1:0] storeData;

    // Decoded fields
    miniCpuPkg::opcode_t    opcode;
    logic [`CPU_DATA_W-1:0] immExt;

    // Decoded controls
    logic useImm;
    logic writesRd;
    logic isLoad;
    logic isStore;
    logic isNop;
    logic accept;

    ////////////////////////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////////////////////////

    // Only taken when fully idle, anything else is dropped
    assign accept = instrValid && (state == miniCpuPkg::sIdle) && !busy;

    // busy lags the state by one edge
    // done pulses on the first idle cycle after busy
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= miniCpuPkg::sIdle;
            busy  <= 1'b0;
            done  <= 1'b0;
        end
        else
        begin
            busy <= (state != miniCpuPkg::sIdle);
            done <= busy && (state == miniCpuPkg::sIdle);
            case (state)
                miniCpuPkg::sIdle:
                begin
                    if (accept)
                    begin
                        state <= miniCpuPkg::sExec;
                    end
                end
                miniCpuPkg::sExec:
                begin
                    state <= miniCpuPkg::sMem;
                end
                miniCpuPkg::sMem:
                begin
                    state <= miniCpuPkg::sWb;
                end
                miniCpuPkg::sWb:
                begin
                    state <= miniCpuPkg::sIdle;
                end
                default:
                begin
                    state <= miniCpuPkg::sIdle;
                end
            endcase
        end
    end

    // Payload registers
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            instrReg <= instr;
        end
        // ALU output and store data captured at end of execute
        if (state == miniCpuPkg::sExec)
        begin
            aluRes    <= aluY;
            storeData <= rtData;
        end
    end

    ////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////

    // Unused codes fall into the default branch
    assign opcode = miniCpuPkg::opcode_t'(instrReg[31:28]);
    assign immExt = {{(`CPU_DATA_W-16){instrReg[15]}}, instrReg[15:0]};

    always_comb
    begin
        aluOp    = miniCpuPkg::aluAdd;
        useImm   = 1'b0;
        writesRd = 1'b0;
        isLoad   = 1'b0;
        isStore  = 1'b0;
        isNop    = 1'b0;
        case (opcode)
            miniCpuPkg::opAdd:
            begin
                writesRd = 1'b1;
            end
            miniCpuPkg::opSub:
            begin
                aluOp    = miniCpuPkg::aluSub;
                writesRd = 1'b1;
            end
            miniCpuPkg::opAnd:
            begin
                aluOp    = miniCpuPkg::aluAnd;
                writesRd = 1'b1;
            end
            miniCpuPkg::opOr:
            begin
                aluOp    = miniCpuPkg::aluOr;
                writesRd = 1'b1;
            end
            miniCpuPkg::opSlt:
            begin
                aluOp    = miniCpuPkg::aluSlt;
                writesRd = 1'b1;
            end
            miniCpuPkg::opAddi:
            begin
                useImm   = 1'b1;
                writesRd = 1'b1;
            end
            // Address is rs plus imm
            miniCpuPkg::opLw:
            begin
                useImm   = 1'b1;
                writesRd = 1'b1;
                isLoad   = 1'b1;
            end
            miniCpuPkg::opSw:
            begin
                useImm  = 1'b1;
                isStore = 1'b1;
            end
            default:
            begin
                isNop = 1'b1;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Datapath controls
    ////////////////////////////////////////////////////////////

    assign rsAddr = instrReg[24:22];
    assign rtAddr = instrReg[21:19];
    assign wrAddr = instrReg[27:25];

    // Operand B is rt or the extended immediate
    assign aluA = rsData;
    assign aluB = useImm ? immExt : rtData;

    // Low address bits only, so addresses wrap
    assign memAddr      = aluRes[`CPU_MEM_ADDR_W-1:0];
    assign memWriteData = storeData;

    // Command only in the memory stage
    always_comb
    begin
        memCmd = miniCpuPkg::memIdle;
        if (state == miniCpuPkg::sMem)
        begin
            if (isStore)
            begin
                memCmd = miniCpuPkg::memWrite;
            end
            else if (isLoad)
            begin
                memCmd = miniCpuPkg::memRead;
            end
        end
    end

    // Writeback value, also the visible result
    // Sources stay put from sWb through the done cycle
    assign result = isLoad  ? readData  :
                    isStore ? storeData :
                    isNop   ? '0        : aluRes;

    assign wrEn = (state == miniCpuPkg::sWb) && writesRd;

endmodule

// File: rtl/miniCpu.sv
`timescale 1ns/1ps
`include "miniCpu_defines.svh"

module miniCpu
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`CPU_DATA_W-1:0]     instr,
    input  logic                       instrValid,
    input  logic                       debugOn,
    input  logic [`CPU_MEM_ADDR_W-1:0] debugAddr,
    output logic                       busy,
    output logic                       done,
    output logic [`CPU_DATA_W-1:0]     result,
    output logic [`CPU_DATA_W-1:0]     memDebug
);

    // Register file hookup
    logic [`CPU_REG_ADDR_W-1:0] rsAddr;
    logic [`CPU_REG_ADDR_W-1:0] rtAddr;
    logic [`CPU_REG_ADDR_W-1:0] wrAddr;
    logic                       wrEn;
    logic [`CPU_DATA_W-1:0]     rsData;
    logic [`CPU_DATA_W-1:0]     rtData;

    // ALU hookup
    miniCpuPkg::aluOp_t     aluOp;
    logic [`CPU_DATA_W-1:0] aluA;
    logic [`CPU_DATA_W-1:0] aluB;
    logic [`CPU_DATA_W-1:0] aluY;

    // Memory hookup
    miniCpuPkg::memCmd_t        memCmd;
    logic [`CPU_MEM_ADDR_W-1:0] memAddr;
    logic [`CPU_DATA_W-1:0]     memWriteData;
    logic [`CPU_DATA_W-1:0]     readData;

    ////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////

    cpuControl cpuControl_i
    (
        .clk          (clk),
        .rst          (rst),
        .instr        (instr),
        .instrValid   (instrValid),
        .rsData       (rsData),
        .rtData       (rtData),
        .aluY         (aluY),
        .readData     (readData),
        .rsAddr       (rsAddr),
        .rtAddr       (rtAddr),
        .wrAddr       (wrAddr),
        .wrEn         (wrEn),
        .aluOp        (aluOp),
        .aluA         (aluA),
        .aluB         (aluB),
        .memCmd       (memCmd),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .busy         (busy),
        .done         (done),
        .result       (result)
    );

    ////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////

    // Writeback data is the result word
    regFile regFile_i
    (
        .clk    (clk),
        .rst    (rst),
        .rsAddr (rsAddr),
        .rtAddr (rtAddr),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .wrData (result),
        .rsData (rsData),
        .rtData (rtData)
    );

    alu alu_i
    (
        .op (aluOp),
        .a  (aluA),
        .b  (aluB),
        .y  (aluY)
    );

    // Debug port goes straight to the pins
    dataMemory dataMemory_i
    (
        .clk       (clk),
        .rst       (rst),
        .cmd       (memCmd),
        .addr      (memAddr),
        .writeData (memWriteData),
        .debugOn   (debugOn),
        .debugAddr (debugAddr),
        .readData  (readData),
        .memDebug  (memDebug)
    );

endmodule

// File: testbench/miniCpu_properties.sv
`timescale 1ns/1ps

module miniCpu_properties
(
    input logic                   clk,
    input logic                   rst,
    input logic                   instrValid,
    input logic                   busy,
    input logic                   done,
    input miniCpuPkg::memCmd_t    memCmd,
    input miniCpuPkg::ctrlState_t state
);

    // Failures seen so far, read by the testbench at the end
    int failCount = 0;

    // Same acceptance rule as the sequencer
    logic accepted;

    assign accepted = instrValid && !busy && (state == miniCpuPkg::sIdle);

    ////////////////////////////////////////////////////////////
    // Control protocol
    ////////////////////////////////////////////////////////////

    doneOneCycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else
    begin
        failCount++;
        $error("done stayed high for more than one cycle");
    end

    // Low through A+3, high after A+4
    doneLowEarly: assert property (@(posedge clk) disable iff (rst) accepted |=> ##3 !done)
    else
    begin
        failCount++;
        $error("done rose before the fourth edge after acceptance");
    end

    doneOnTime: assert property (@(posedge clk) disable iff (rst) accepted |-> ##5 done)
    else
    begin
        failCount++;
        $error("done missing four edges after acceptance");
    end

    idleAfterReset: assert property (@(posedge clk) $fell(rst) |-> (!busy && !done))
    else
    begin
        failCount++;
        $error("busy or done high when reset released");
    end

    // Memory stage sits two edges after acceptance
    cmdInMemStage: assert property (@(posedge clk) disable iff (rst)
        (memCmd != miniCpuPkg::memIdle) |-> $past(accepted, 2))
    else
    begin
        failCount++;
        $error("memory command issued outside the memory stage");
    end

endmodule

bind miniCpu miniCpu_properties miniCpu_properties_i
(
    .clk        (clk),
    .rst        (rst),
    .instrValid (instrValid),
    .busy       (busy),
    .done       (done),
    .memCmd     (memCmd),
    .state      (cpuControl_i.state)
);

// File: testbench/miniCpu_tb.sv
`timescale 1ns/1ps
`include "miniCpu_defines.svh"

module miniCpu_tb;

    ////////////////////////////////////////////////////////////
    // Run length
    ////////////////////////////////////////////////////////////

    localparam int clkPeriod   = 8;
    localparam int resetCycles = 8;
    localparam int randRounds  = 8;
    localparam int opsPerRound = 16;

    // Register loads and random ops, store and load loops, directed cases
    localparam int instrBudget = randRounds * (`CPU_REG_COUNT - 1 + opsPerRound)
                                 + 4 * `CPU_MEM_DEPTH + 20;
    // Six cycles per instruction plus debug reads, half again as margin
    localparam int cycleLimit  = (instrBudget * 6 + 2 * `CPU_MEM_DEPTH + resetCycles) * 3 / 2;

    logic                       clk;
    logic                       rst;
    logic [`CPU_DATA_W-1:0]     instr;
    logic                       instrValid;
    logic                       debugOn;
    logic [`CPU_MEM_ADDR_W-1:0] debugAddr;
    logic                       busy;
    logic                       done;
    logic [`CPU_DATA_W-1:0]     result;
    logic [`CPU_DATA_W-1:0]     memDebug;

    // Reference machine state
    logic [`CPU_DATA_W-1:0] refRegs [`CPU_REG_COUNT];
    logic [`CPU_DATA_W-1:0] refMem [`CPU_MEM_DEPTH];
    logic                   refMemValid [`CPU_MEM_DEPTH];

    // Expected results in issue order
    logic [`CPU_DATA_W-1:0] expQ [$];
    string                  nameQ [$];

    integer                 seed;
    logic [31:0]            rnd;
    logic [3:0]             opSel;
    logic [15:0]            immVal;
    logic [2:0]             baseReg;
    logic [`CPU_DATA_W-1:0] checkExp;
    string                  checkName;
    int                     cycleCount     = 0;
    int                     resultErrors   = 0;
    int                     memErrors      = 0;
    int                     protocolErrors = 0;
    logic                   timedOut       = 1'b0;

    miniCpu miniCpu_i
    (
        .clk        (clk),
        .rst        (rst),
        .instr      (instr),
        .instrValid (instrValid),
        .debugOn    (debugOn),
        .debugAddr  (debugAddr),
        .busy       (busy),
        .done       (done),
        .result     (result),
        .memDebug   (memDebug)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    // Result of one instruction, registers and memory updated as a side effect
    function automatic logic [31:0] refExecute(input logic [31:0] ins);
        logic [3:0]  op;
        logic [2:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] ea;
        logic [31:0] res;
        logic        writes;
        op     = ins[31:28];
        rd     = ins[27:25];
        a      = refRegs[ins[24:22]];
        b      = refRegs[ins[21:19]];
        imm    = {{16{ins[15]}}, ins[15:0]};
        ea     = a + imm;
        res    = '0;
        writes = 1'b1;
        case (op)
            miniCpuPkg::opAdd:  res = a + b;
            miniCpuPkg::opSub:  res = a - b;
            miniCpuPkg::opAnd:  res = a & b;
            miniCpuPkg::opOr:   res = a | b;
            miniCpuPkg::opSlt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            miniCpuPkg::opAddi: res = ea;
            // Word address wraps to the low bits
            miniCpuPkg::opLw:   res = refMem[ea[`CPU_MEM_ADDR_W-1:0]];
            miniCpuPkg::opSw:
            begin
                refMem[ea[`CPU_MEM_ADDR_W-1:0]]      = b;
                refMemValid[ea[`CPU_MEM_ADDR_W-1:0]] = 1'b1;
                res    = b;
                writes = 1'b0;
            end
            default:
            begin
                writes = 1'b0;
            end
        endcase
        // r0 stays zero
        if (writes && (rd != 3'd0))
            refRegs[rd] = res;
        return res;
    endfunction

    function automatic logic [31:0] encodeInstr(input logic [3:0] op, input logic [2:0] rd,
                                                input logic [2:0] rs, input logic [2:0] rt,
                                                input logic [15:0] imm);
        return {op, rd, rs, rt, 3'b000, imm};
    endfunction

    function automatic string opName(input logic [3:0] op);
        case (op)
            miniCpuPkg::opAdd: return "add";
            miniCpuPkg::opSub: return "sub";
            miniCpuPkg::opAnd: return "and";
            miniCpuPkg::opOr:  return "or";
            default:           return "slt";
        endcase
    endfunction

    function automatic logic [31:0] randWord();
        return $random(seed);
    endfunction

    ////////////////////////////////////////////////////////////
    // Drivers
    ////////////////////////////////////////////////////////////

    // Returns one ns after the edge that raised done
    task automatic waitDone();
        while (!done)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic issue(input string name, input logic [31:0] word);
        expQ.push_back(refExecute(word));
        nameQ.push_back(name);
        instr      = word;
        instrValid = 1'b1;
        @(posedge clk);
        #1;
        instrValid = 1'b0;
        waitDone();
    endtask

    // Second strobe some cycles into the first instruction
    task automatic issueWithIgnored(input string name, input logic [31:0] word,
                                    input logic [31:0] ignoredWord, input int lateCycles);
        expQ.push_back(refExecute(word));
        nameQ.push_back(name);
        instr      = word;
        instrValid = 1'b1;
        @(posedge clk);
        #1;
        instrValid = 1'b0;
        repeat (lateCycles) @(posedge clk);
        #1;
        assert (busy)
        else
        begin
            protocolErrors++;
            $display("busy was low while an instruction was still in flight");
        end
        instr      = ignoredWord;
        instrValid = 1'b1;
        @(posedge clk);
        #1;
        instrValid = 1'b0;
        waitDone();
    endtask

    // Debug read lands one edge after debugOn
    task automatic checkMemWord(input string name, input logic [4:0] addr);
        debugAddr = addr;
        debugOn   = 1'b1;
        @(posedge clk);
        #1;
        debugOn = 1'b0;
        assert (memDebug == refMem[addr])
        else
        begin
            memErrors++;
            $display("error %s[%0d] expected %h actual %h", name, addr, refMem[addr], memDebug);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Checking and verdict
    ////////////////////////////////////////////////////////////

    // Sampled mid-cycle, away from the clock edge
    always @(negedge clk)
    begin
        if (!rst && done)
        begin
            if (expQ.size() == 0)
            begin
                protocolErrors++;
                $display("done pulsed with no instruction outstanding at %0t", $time);
            end
            else
            begin
                checkExp  = expQ.pop_front();
                checkName = nameQ.pop_front();
                assert (result == checkExp)
                else
                begin
                    resultErrors++;
                    $display("error %s expected %h actual %h", checkName, checkExp, result);
                end
            end
        end
    end

    task automatic finishRun();
        int assertFails;
        assertFails = miniCpu_i.miniCpu_properties_i.failCount;
        $display("Errors: result %0d, memory %0d, protocol %0d, assertion %0d",
                 resultErrors, memErrors, protocolErrors, assertFails);
        if (!timedOut && (resultErrors + memErrors + protocolErrors + assertFails == 0))
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    endtask

    always @(posedge clk)
    begin
        cycleCount++;
        if (cycleCount >= cycleLimit)
        begin
            $display("Timeout: the run went past %0d cycles without finishing", cycleLimit);
            timedOut = 1'b1;
            finishRun();
        end
    end

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////

    task automatic testReset();
        assert (!busy && !done)
        else
        begin
            protocolErrors++;
            $display("busy or done was high right after reset");
        end
        assert (memDebug == '0)
        else
        begin
            memErrors++;
            $display("error reset_memDebug expected %h actual %h", 32'h0, memDebug);
        end
    endtask

    task automatic testRandomOps();
        for (int round = 0; round < randRounds; round++)
        begin
            // Fresh operands from r0
            for (int r = 1; r < `CPU_REG_COUNT; r++)
            begin
                rnd = randWord();
                issue("load_addi", encodeInstr(miniCpuPkg::opAddi, 3'(r), 3'd0, 3'd0,
                                               rnd[15:0]));
            end
            for (int k = 0; k < opsPerRound; k++)
            begin
                rnd   = randWord();
                opSel = 4'(rnd[31:29] % 3'd5);
                issue(opName(opSel), encodeInstr(opSel, rnd[2:0], rnd[5:3], rnd[8:6], 16'h0));
            end
        end
    endtask

    task automatic testImmediates();
        issue("addi_neg", encodeInstr(miniCpuPkg::opAddi, 3'd1, 3'd0, 3'd0, 16'hfffb));
        issue("addi_neg_min", encodeInstr(miniCpuPkg::opAddi, 3'd2, 3'd1, 3'd0, 16'h8000));
        // Result still shows, r0 untouched
        issue("addi_r0", encodeInstr(miniCpuPkg::opAddi, 3'd0, 3'd0, 3'd0, 16'h1234));
        issue("add_r0_r0", encodeInstr(miniCpuPkg::opAdd, 3'd3, 3'd0, 3'd0, 16'h0));
        issue("add_r0_r2", encodeInstr(miniCpuPkg::opAdd, 3'd3, 3'd0, 3'd2, 16'h0));
    endtask

    task automatic testStores();
        // Base of -32 lands back on the same word
        issue("addi_base", encodeInstr(miniCpuPkg::opAddi, 3'd7, 3'd0, 3'd0, 16'hffe0));
        for (int i = 0; i < `CPU_MEM_DEPTH; i++)
        begin
            rnd = randWord();
            issue("addi_data", encodeInstr(miniCpuPkg::opAddi, 3'd6, 3'd0, 3'd0, rnd[15:0]));
            // Even words from r0 with offsets above 31
            if (i % 2 == 0)
            begin
                baseReg = 3'd0;
                immVal  = 16'(i + 32 * (1 + int'(rnd[18:16])));
            end
            else
            begin
                baseReg = 3'd7;
                immVal  = 16'(i);
            end
            issue("sw", encodeInstr(miniCpuPkg::opSw, 3'd0, baseReg, 3'd6, immVal));
        end
        for (int a = 0; a < `CPU_MEM_DEPTH; a++)
        begin
            if (refMemValid[a])
                checkMemWord("sw_debug", 5'(a));
        end
        // Debug output holds with debugOn low
        // New address must not show through
        debugAddr = '0;
        repeat (2) @(posedge clk);
        #1;
        assert (memDebug == refMem[`CPU_MEM_DEPTH-1])
        else
        begin
            memErrors++;
            $display("error debug_hold expected %h actual %h",
                     refMem[`CPU_MEM_DEPTH-1], memDebug);
        end
    endtask

    task automatic testLoads();
        for (int i = 0; i < `CPU_MEM_DEPTH; i++)
        begin
            rnd     = randWord();
            baseReg = rnd[7] ? 3'd7 : 3'd0;
            immVal  = 16'(int'(rnd[4:0]) + 32 * int'(rnd[6:5]));
            issue("lw", encodeInstr(miniCpuPkg::opLw, 3'd4, baseReg, 3'd0, immVal));
            // Loaded register feeds the next op
            issue("add_loaded", encodeInstr(miniCpuPkg::opAdd, 3'd5, 3'd4, 3'd2, 16'h0));
        end
    endtask

    task automatic testIgnoredStrobe();
        for (int late = 1; late <= 3; late += 2)
        begin
            rnd = randWord();
            issueWithIgnored("first_of_pair",
                             encodeInstr(miniCpuPkg::opAddi, 3'd3, 3'd0, 3'd0, rnd[15:0]),
                             encodeInstr(miniCpuPkg::opAddi, 3'd5, 3'd0, 3'd0, 16'h0777),
                             late);
            // r5 must still hold its earlier value
            issue("read_back", encodeInstr(miniCpuPkg::opOr, 3'd6, 3'd5, 3'd3, 16'h0));
        end
    endtask

    initial
    begin
        seed       = 32'h6acef672;
        rst        = 1'b1;
        instr      = '0;
        instrValid = 1'b0;
        debugOn    = 1'b0;
        debugAddr  = '0;
        for (int i = 0; i < `CPU_REG_COUNT; i++)
            refRegs[i] = '0;
        for (int i = 0; i < `CPU_MEM_DEPTH; i++)
        begin
            refMem[i]      = '0;
            refMemValid[i] = 1'b0;
        end
        repeat (resetCycles) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;
        testReset();
        testRandomOps();
        testImmediates();
        testStores();
        testLoads();
        testIgnoredStrobe();
        @(posedge clk);
        #1;
        assert (expQ.size() == 0)
        else
        begin
            protocolErrors++;
            $display("%0d instructions never signalled done", expQ.size());
        end
        finishRun();
    end

endmodule

// File: miniCpu.f
+incdir+rtl
rtl/miniCpuPkg.sv
rtl/regFile.sv
rtl/alu.sv
rtl/dataMemory.sv
rtl/cpuControl.sv
rtl/miniCpu.sv
testbench/miniCpu_properties.sv
testbench/miniCpu_tb.sv

// File: Makefile
# Verilator build and run for miniCpu

VERILATOR ?= verilator
TOP       ?= miniCpu_tb
FILELIST  ?= miniCpu.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/1ps
SIMFLAGS  ?= +verilator+error+limit+1000

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard rtl/*.svh)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM) $(SIMFLAGS))"; echo "$$out"; \
	echo "$$out" | grep -qxF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)
